// ==== logic/cpu_defs.svh ====
/*
 * CPU core parameters
 * widths, reset vector and MIPS-I instruction field positions
 * shared by the core units and the testbench
 */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

//////////////////////////////
// widths
//////////////////////////////
`define CPU_DW        32        // data and address width
`define CPU_RW        5         // register index width
`define CPU_NREGS     32        // register count, r0 included
`define CPU_RESET_PC  32'h0     // first fetch after reset

//////////////////////////////
// instruction fields
//////////////////////////////
`define CPU_OP_MSB      31
`define CPU_OP_LSB      26
`define CPU_RS_MSB      25
`define CPU_RS_LSB      21
`define CPU_RT_MSB      20
`define CPU_RT_LSB      16
`define CPU_RD_MSB      15
`define CPU_RD_LSB      11
`define CPU_FUNCT_MSB   5
`define CPU_FUNCT_LSB   0
`define CPU_IMM_MSB     15
`define CPU_IMM_LSB     0
`define CPU_TARGET_MSB  25
`define CPU_TARGET_LSB  0

`endif

// ==== logic/cpu_pkg.sv ====
/*
 * CPU types
 * opcode and function encodings, ALU operations, datapath selects
 * and the decoded control word
 */
`default_nettype none

package cpu_pkg;

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		op_special = 6'h00,     // R-format, see funct
		op_j       = 6'h02,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_slti    = 6'h0a,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_xori    = 6'h0e,
		op_lui     = 6'h0f,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} opcode_e;

	// R-format function, instr[5:0]
	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_nor  = 6'h27,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_nor, alu_slt, alu_sltu, alu_pass_b      // pass_b serves lui
	} alu_op_e;

	typedef enum logic [1:0] {src_b_rt, src_b_sext, src_b_zext, src_b_upper} src_b_e;
	typedef enum logic {wb_alu, wb_load} wb_sel_e;
	typedef enum logic [1:0] {npc_seq, npc_beq, npc_bne, npc_jump} next_pc_e;

	// decoded control, one per instruction
	typedef struct packed {
		alu_op_e  alu_op;
		src_b_e   src_b;
		wb_sel_e  wb_sel;
		next_pc_e next_pc;
		logic     reg_write;
		logic     dst_is_rd;    // rd for R-format, else rt
		logic     mem_read;
		logic     mem_write;
	} ctrl_t;

endpackage

`default_nettype wire

// ==== logic/cpu_decoder.sv ====
/*
 * Instruction decoder
 * maps opcode and funct of one instruction word to the control word,
 * anything unknown becomes a nop that writes nothing and goes sequential
 */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_decoder (
	input  wire logic [`CPU_DW-1:0] instr_i,
	output cpu_pkg::ctrl_t          ctrl_o
);

	cpu_pkg::opcode_e opcode;
	cpu_pkg::funct_e  funct;

	assign opcode = cpu_pkg::opcode_e'(instr_i[`CPU_OP_MSB:`CPU_OP_LSB]);
	assign funct  = cpu_pkg::funct_e'(instr_i[`CPU_FUNCT_MSB:`CPU_FUNCT_LSB]);

	always_comb begin
		// nop defaults
		ctrl_o.alu_op    = cpu_pkg::alu_add;
		ctrl_o.src_b     = cpu_pkg::src_b_rt;
		ctrl_o.wb_sel    = cpu_pkg::wb_alu;
		ctrl_o.next_pc   = cpu_pkg::npc_seq;
		ctrl_o.reg_write = 1'b0;
		ctrl_o.dst_is_rd = 1'b0;
		ctrl_o.mem_read  = 1'b0;
		ctrl_o.mem_write = 1'b0;

		case (opcode)
			//////////////////////////////
			// R-format
			//////////////////////////////
			cpu_pkg::op_special: begin
				ctrl_o.reg_write = 1'b1;
				ctrl_o.dst_is_rd = 1'b1;
				case (funct)
					cpu_pkg::fn_addu: ctrl_o.alu_op = cpu_pkg::alu_add;
					cpu_pkg::fn_subu: ctrl_o.alu_op = cpu_pkg::alu_sub;
					cpu_pkg::fn_and:  ctrl_o.alu_op = cpu_pkg::alu_and;
					cpu_pkg::fn_or:   ctrl_o.alu_op = cpu_pkg::alu_or;
					cpu_pkg::fn_xor:  ctrl_o.alu_op = cpu_pkg::alu_xor;
					cpu_pkg::fn_nor:  ctrl_o.alu_op = cpu_pkg::alu_nor;
					cpu_pkg::fn_slt:  ctrl_o.alu_op = cpu_pkg::alu_slt;
					cpu_pkg::fn_sltu: ctrl_o.alu_op = cpu_pkg::alu_sltu;
					default: begin                  // unknown funct, back to nop
						ctrl_o.reg_write = 1'b0;
						ctrl_o.dst_is_rd = 1'b0;
					end
				endcase
			end

			//////////////////////////////
			// I-format alu
			//////////////////////////////
			cpu_pkg::op_addiu: begin
				ctrl_o.src_b     = cpu_pkg::src_b_sext;
				ctrl_o.reg_write = 1'b1;
			end
			cpu_pkg::op_slti: begin
				ctrl_o.alu_op    = cpu_pkg::alu_slt;
				ctrl_o.src_b     = cpu_pkg::src_b_sext;   // signed imm, signed compare
				ctrl_o.reg_write = 1'b1;
			end
			cpu_pkg::op_andi: begin
				ctrl_o.alu_op    = cpu_pkg::alu_and;
				ctrl_o.src_b     = cpu_pkg::src_b_zext;
				ctrl_o.reg_write = 1'b1;
			end
			cpu_pkg::op_ori: begin
				ctrl_o.alu_op    = cpu_pkg::alu_or;
				ctrl_o.src_b     = cpu_pkg::src_b_zext;
				ctrl_o.reg_write = 1'b1;
			end
			cpu_pkg::op_xori: begin
				ctrl_o.alu_op    = cpu_pkg::alu_xor;
				ctrl_o.src_b     = cpu_pkg::src_b_zext;
				ctrl_o.reg_write = 1'b1;
			end
			cpu_pkg::op_lui: begin
				ctrl_o.alu_op    = cpu_pkg::alu_pass_b;   // imm << 16 straight through
				ctrl_o.src_b     = cpu_pkg::src_b_upper;
				ctrl_o.reg_write = 1'b1;
			end

			//////////////////////////////
			// memory
			//////////////////////////////
			cpu_pkg::op_lw: begin
				ctrl_o.src_b     = cpu_pkg::src_b_sext;   // base + offset
				ctrl_o.wb_sel    = cpu_pkg::wb_load;
				ctrl_o.reg_write = 1'b1;
				ctrl_o.mem_read  = 1'b1;
			end
			cpu_pkg::op_sw: begin
				ctrl_o.src_b     = cpu_pkg::src_b_sext;
				ctrl_o.mem_write = 1'b1;
			end

			//////////////////////////////
			// flow
			//////////////////////////////
			cpu_pkg::op_beq: ctrl_o.next_pc = cpu_pkg::npc_beq;   // alu eq flag on rs, rt
			cpu_pkg::op_bne: ctrl_o.next_pc = cpu_pkg::npc_bne;
			cpu_pkg::op_j:   ctrl_o.next_pc = cpu_pkg::npc_jump;

			default: ;      // unknown opcode keeps the nop
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/cpu_regfile.sv ====
/*
 * Register file
 * 31 writable registers, r0 hardwired to zero
 * two combinational read ports, one write port on the rising edge
 */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_regfile (
	input  wire logic              clk_i,
	input  wire logic              rst_i,
	input  wire logic [`CPU_RW-1:0] rs_idx_i,
	input  wire logic [`CPU_RW-1:0] rt_idx_i,
	output      logic [`CPU_DW-1:0] rs_data_o,
	output      logic [`CPU_DW-1:0] rt_data_o,
	input  wire logic [`CPU_RW-1:0] wr_idx_i,
	input  wire logic [`CPU_DW-1:0] wr_data_i,
	input  wire logic              wr_en_i
);

	logic [`CPU_DW-1:0] regs [1:`CPU_NREGS-1];     // no storage for r0

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 1; i < `CPU_NREGS; i++)
				regs[i] <= '0;
		end else if (wr_en_i && (wr_idx_i != '0)) begin   // r0 writes dropped
			regs[wr_idx_i] <= wr_data_i;
		end
	end

	// reads, r0 forced to zero
	assign rs_data_o = (rs_idx_i == '0) ? '0 : regs[rs_idx_i];
	assign rt_data_o = (rt_idx_i == '0) ? '0 : regs[rt_idx_i];

endmodule

`default_nettype wire

// ==== logic/cpu_alu.sv ====
/*
 * ALU
 * add, sub, logic ops, signed and unsigned set-less-than, pass of b;
 * zero_o flags a equal to b for the branch logic
 */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_alu (
	input  cpu_pkg::alu_op_e        op_i,
	input  wire logic [`CPU_DW-1:0] a_i,
	input  wire logic [`CPU_DW-1:0] b_i,
	output      logic [`CPU_DW-1:0] result_o,
	output      logic               zero_o
);

	logic [`CPU_DW-1:0] diff;      // shared by sub and eq
	logic               lt_s;
	logic               lt_u;

	assign diff = a_i - b_i;
	assign lt_s = $signed(a_i) < $signed(b_i);
	assign lt_u = a_i < b_i;

	always_comb begin
		case (op_i)
			cpu_pkg::alu_add:    result_o = a_i + b_i;
			cpu_pkg::alu_sub:    result_o = diff;
			cpu_pkg::alu_and:    result_o = a_i & b_i;
			cpu_pkg::alu_or:     result_o = a_i | b_i;
			cpu_pkg::alu_xor:    result_o = a_i ^ b_i;
			cpu_pkg::alu_nor:    result_o = ~(a_i | b_i);
			cpu_pkg::alu_slt:    result_o = {{(`CPU_DW-1){1'b0}}, lt_s};   // 1 or 0
			cpu_pkg::alu_sltu:   result_o = {{(`CPU_DW-1){1'b0}}, lt_u};
			cpu_pkg::alu_pass_b: result_o = b_i;                           // lui
			default:             result_o = '0;
		endcase
	end

	// equality for beq/bne, independent of op
	assign zero_o = (diff == '0);

endmodule

`default_nettype wire

// ==== logic/cpu_pc.sv ====
/*
 * Program counter
 * holds pc and picks the next fetch address:
 * pc+4, taken branch or jump, with no delay slot
 */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_pc (
	input  wire logic               clk_i,
	input  wire logic               rst_i,
	input  cpu_pkg::next_pc_e       next_pc_i,
	input  wire logic               eq_i,       // rs == rt from the alu
	input  wire logic [15:0]        imm_i,      // branch offset, in words
	input  wire logic [25:0]        target_i,   // jump target, in words
	output      logic [`CPU_DW-1:0] pc_o
);

	logic [`CPU_DW-1:0] pc_q;
	logic [`CPU_DW-1:0] pc_plus4;
	logic [`CPU_DW-1:0] pc_branch;
	logic [`CPU_DW-1:0] pc_jump;
	logic [`CPU_DW-1:0] pc_next;

	//////////////////////////////
	// candidate addresses
	//////////////////////////////
	assign pc_plus4  = pc_q + `CPU_DW'd4;
	assign pc_branch = pc_plus4 + {{(`CPU_DW-18){imm_i[15]}}, imm_i, 2'b00};
	assign pc_jump   = {pc_plus4[`CPU_DW-1:`CPU_DW-4], target_i, 2'b00};   // same 256MB region

	always_comb begin
		case (next_pc_i)
			cpu_pkg::npc_beq:  pc_next = eq_i ? pc_branch : pc_plus4;
			cpu_pkg::npc_bne:  pc_next = eq_i ? pc_plus4 : pc_branch;
			cpu_pkg::npc_jump: pc_next = pc_jump;
			default:           pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i)
			pc_q <= `CPU_RESET_PC;
		else
			pc_q <= pc_next;
	end

	assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
/*
 * Single-cycle MIPS-I subset core
 * Harvard split with one instruction and one data port,
 * one instruction completes per clock
 */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_core (
	input  wire logic               clk_i,
	input  wire logic               rst_i,
	// instruction port
	output      logic [`CPU_DW-1:0] imem_addr_o,
	input  wire logic [`CPU_DW-1:0] imem_data_i,    // same-cycle answer
	// data port
	output      logic [`CPU_DW-1:0] dmem_addr_o,
	output      logic [`CPU_DW-1:0] dmem_wdata_o,
	input  wire logic [`CPU_DW-1:0] dmem_rdata_i,   // valid while dmem_rd_o
	output      logic               dmem_wr_o,      // sampled on rising edge
	output      logic               dmem_rd_o
);

	cpu_pkg::ctrl_t ctrl;

	logic [`CPU_RW-1:0] rs_idx;
	logic [`CPU_RW-1:0] rt_idx;
	logic [`CPU_RW-1:0] rd_idx;
	logic [`CPU_RW-1:0] dst_idx;
	logic [15:0]        imm;
	logic [25:0]        target;

	logic [`CPU_DW-1:0] rs_data;
	logic [`CPU_DW-1:0] rt_data;
	logic [`CPU_DW-1:0] src_b;
	logic [`CPU_DW-1:0] alu_result;
	logic               alu_eq;
	logic [`CPU_DW-1:0] wb_data;

	//////////////////////////////
	// fetch and fields
	//////////////////////////////
	cpu_pc u_pc (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.next_pc_i (ctrl.next_pc),
		.eq_i      (alu_eq),
		.imm_i     (imm),
		.target_i  (target),
		.pc_o      (imem_addr_o)
	);

	assign rs_idx = imem_data_i[`CPU_RS_MSB:`CPU_RS_LSB];
	assign rt_idx = imem_data_i[`CPU_RT_MSB:`CPU_RT_LSB];
	assign rd_idx = imem_data_i[`CPU_RD_MSB:`CPU_RD_LSB];
	assign imm    = imem_data_i[`CPU_IMM_MSB:`CPU_IMM_LSB];
	assign target = imem_data_i[`CPU_TARGET_MSB:`CPU_TARGET_LSB];

	cpu_decoder u_decoder (
		.instr_i (imem_data_i),
		.ctrl_o  (ctrl)
	);

	//////////////////////////////
	// registers
	//////////////////////////////
	assign dst_idx = ctrl.dst_is_rd ? rd_idx : rt_idx;     // rd for R-format
	assign wb_data = (ctrl.wb_sel == cpu_pkg::wb_load) ? dmem_rdata_i : alu_result;

	cpu_regfile u_regfile (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.rs_idx_i  (rs_idx),
		.rt_idx_i  (rt_idx),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data),
		.wr_idx_i  (dst_idx),
		.wr_data_i (wb_data),
		.wr_en_i   (ctrl.reg_write)
	);

	//////////////////////////////
	// execute
	//////////////////////////////
	always_comb begin
		case (ctrl.src_b)
			cpu_pkg::src_b_sext:  src_b = {{(`CPU_DW-16){imm[15]}}, imm};
			cpu_pkg::src_b_zext:  src_b = {{(`CPU_DW-16){1'b0}}, imm};
			cpu_pkg::src_b_upper: src_b = {imm, 16'h0000};    // lui
			default:              src_b = rt_data;
		endcase
	end

	cpu_alu u_alu (
		.op_i     (ctrl.alu_op),
		.a_i      (rs_data),
		.b_i      (src_b),
		.result_o (alu_result),
		.zero_o   (alu_eq)
	);

	//////////////////////////////
	// data port
	//////////////////////////////
	assign dmem_addr_o  = alu_result;                   // base + offset
	assign dmem_wdata_o = rt_data;
	assign dmem_rd_o    = ctrl.mem_read;
	assign dmem_wr_o    = ctrl.mem_write & ~rst_i;      // no stray store in reset

endmodule

`default_nettype wire

// ==== testbench/cpu_props.sv ====
/*
 * Core port properties
 * data strobes exclusive and quiet in reset,
 * fetch address aligned and at the reset vector after reset
 */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_props (
	input wire logic               clk_i,
	input wire logic               rst_i,
	input wire logic [`CPU_DW-1:0] imem_addr_i,
	input wire logic               dmem_wr_i,
	input wire logic               dmem_rd_i
);

	int unsigned fail_cnt = 0;      // failed assertions so far

	strobes_exclusive: assert property (@(posedge clk_i) !(dmem_wr_i && dmem_rd_i))
		else begin
			fail_cnt++;
			$error("dmem_wr_o and dmem_rd_o high together");
		end

	no_store_in_reset: assert property (@(posedge clk_i) rst_i |-> !dmem_wr_i)
		else begin
			fail_cnt++;
			$error("dmem_wr_o high during reset");
		end

	fetch_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
		imem_addr_i[1:0] == 2'b00)
		else begin
			fail_cnt++;
			$error("imem_addr_o not word aligned: %h", imem_addr_i);
		end

	// first cycle out of reset fetches the vector
	fetch_reset_vector: assert property (@(posedge clk_i)
		$fell(rst_i) |-> imem_addr_i == `CPU_RESET_PC)
		else begin
			fail_cnt++;
			$error("imem_addr_o %h after reset", imem_addr_i);
		end

endmodule

bind cpu_core cpu_props u_props (
	.clk_i       (clk_i),
	.rst_i       (rst_i),
	.imem_addr_i (imem_addr_o),
	.dmem_wr_i   (dmem_wr_o),
	.dmem_rd_i   (dmem_rd_o)
);

`default_nettype wire

// ==== testbench/cpu_tb.sv ====
/*
 * Testbench for the single-cycle core
 * builds a short program per table entry, runs it from reset and
 * checks the word the program stores at the result address
 */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_tb;

	localparam int          N_TESTS     = 26;
	localparam int          RUN_CYCLES  = 16;              // longest program is 9 instructions
	localparam int          TEST_CYCLES = RUN_CYCLES + 2;  // plus reset
	localparam int          WATCHDOG_NS = N_TESTS * TEST_CYCLES * 10 * 2;
	localparam int          MEM_WORDS   = 64;
	localparam logic [31:0] RES_ADDR    = 32'h0000_0080;   // result word
	localparam logic [31:0] SKIP_ADDR   = 32'h0000_0084;   // store that a j jumps over
	localparam logic [31:0] PARK_ADDR   = 32'h0000_0088;   // sw/lw round trip

	typedef enum logic [2:0] {k_rtype, k_itype, k_mem, k_branch, k_zero} kind_e;

	typedef struct packed {
		kind_e       kind;
		logic [5:0]  code;      // funct for k_rtype, else opcode
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] exp;
	} test_t;

	logic clk = 1'b0;
	logic rst;
	logic [`CPU_DW-1:0] imem_addr, imem_data;
	logic [`CPU_DW-1:0] dmem_addr, dmem_wdata, dmem_rdata;
	logic               dmem_wr, dmem_rd;

	logic [31:0] imem [MEM_WORDS];
	logic [31:0] dmem [MEM_WORDS];
	logic [31:0] stored;            // last store seen at RES_ADDR
	int          wr_count;          // dmem_wr_o pulses since reset
	test_t       tests [N_TESTS];
	int          n_built, pc_w, n_pass, n_fail;

	always #5 clk = ~clk;

	cpu_core dut (
		.clk_i        (clk),
		.rst_i        (rst),
		.imem_addr_o  (imem_addr),
		.imem_data_i  (imem_data),
		.dmem_addr_o  (dmem_addr),
		.dmem_wdata_o (dmem_wdata),
		.dmem_rdata_i (dmem_rdata),
		.dmem_wr_o    (dmem_wr),
		.dmem_rd_o    (dmem_rd)
	);

	//////////////////////////////
	// memory models
	//////////////////////////////
	assign imem_data  = imem[imem_addr[7:2]];                  // combinational fetch
	assign dmem_rdata = dmem_rd ? dmem[dmem_addr[7:2]] : 32'h0;

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MEM_WORDS; i++)
				dmem[i] <= 32'h5a5a_0000 ^ i;                  // address-tagged fill
			wr_count <= 0;
			stored   <= 32'hdead_beef;
		end else if (dmem_wr) begin
			dmem[dmem_addr[7:2]] <= dmem_wdata;
			wr_count <= wr_count + 1;
			if (dmem_addr == RES_ADDR)
				stored <= dmem_wdata;
		end
	end

	//////////////////////////////
	// instruction words
	//////////////////////////////
	function automatic logic [31:0] r_format(int rs, int rt, int rd, cpu_pkg::funct_e fn);
		return {cpu_pkg::op_special, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_format(cpu_pkg::opcode_e op, int rs, int rt,
	                                         logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] j_word(int target);
		return {cpu_pkg::op_j, 26'(target)};
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[pc_w] = w;
		pc_w++;
	endtask

	// reference results straight from the instruction set rules
	function automatic logic [31:0] expected_of(kind_e kind, logic [5:0] code,
	                                            logic [31:0] a, logic [31:0] b);
		logic [31:0] sx;
		logic [31:0] zx;
		logic        taken;
		sx    = {{16{b[15]}}, b[15:0]};
		zx    = {16'h0, b[15:0]};
		taken = (code == cpu_pkg::op_beq) ? (a == b) : (a != b);
		case (kind)
			k_rtype: case (code)
				cpu_pkg::fn_addu: return a + b;
				cpu_pkg::fn_subu: return a - b;
				cpu_pkg::fn_and:  return a & b;
				cpu_pkg::fn_or:   return a | b;
				cpu_pkg::fn_xor:  return a ^ b;
				cpu_pkg::fn_nor:  return ~(a | b);
				cpu_pkg::fn_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				default:          return (a < b) ? 32'd1 : 32'd0;    // sltu
			endcase
			k_itype: case (code)
				cpu_pkg::op_addiu: return a + sx;
				cpu_pkg::op_slti:  return ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
				cpu_pkg::op_andi:  return a & zx;
				cpu_pkg::op_ori:   return a | zx;
				cpu_pkg::op_xori:  return a ^ zx;
				default:           return {b[15:0], 16'h0};         // lui
			endcase
			k_mem:    return a;
			k_branch: return taken ? 32'd1 : 32'd2;      // marker kept when skipped
			default:  return 32'h0;                      // r0 stays zero
		endcase
	endfunction

	task automatic add_test(input kind_e kind, input logic [5:0] code,
	                        input logic [31:0] a, input logic [31:0] b);
		tests[n_built] = '{kind, code, a, b, expected_of(kind, code, a, b)};
		n_built++;
	endtask

	task automatic build_table();
		cpu_pkg::funct_e  fns [8];
		cpu_pkg::opcode_e iops [6];
		logic [31:0]      a;
		logic [31:0]      b;
		fns  = '{cpu_pkg::fn_addu, cpu_pkg::fn_subu, cpu_pkg::fn_and, cpu_pkg::fn_or,
		         cpu_pkg::fn_xor, cpu_pkg::fn_nor, cpu_pkg::fn_slt, cpu_pkg::fn_sltu};
		iops = '{cpu_pkg::op_addiu, cpu_pkg::op_slti, cpu_pkg::op_andi,
		         cpu_pkg::op_ori, cpu_pkg::op_xori, cpu_pkg::op_lui};
		n_built = 0;
		foreach (fns[i]) begin
			a = $urandom;
			b = $urandom;
			add_test(k_rtype, fns[i], a, b);
		end
		a = $urandom | 32'h8000_0000;       // top bits differ
		b = $urandom & 32'h7fff_ffff;
		add_test(k_rtype, cpu_pkg::fn_slt, a, b);
		add_test(k_rtype, cpu_pkg::fn_sltu, a, b);
		add_test(k_rtype, cpu_pkg::fn_slt, b, a);
		add_test(k_rtype, cpu_pkg::fn_sltu, b, a);
		foreach (iops[i]) begin
			a = $urandom;
			b = $urandom;
			add_test(k_itype, iops[i], a, b);
		end
		a = $urandom & 32'h0000_7fff;
		b = $urandom | 32'h0000_8000;       // negative imm
		add_test(k_itype, cpu_pkg::op_addiu, a, b);
		add_test(k_itype, cpu_pkg::op_slti, a, b);
		add_test(k_mem, cpu_pkg::op_lw, $urandom, 32'h0);
		a = $urandom;
		add_test(k_branch, cpu_pkg::op_beq, a, a);
		add_test(k_branch, cpu_pkg::op_beq, a, a ^ 32'h1);
		add_test(k_branch, cpu_pkg::op_bne, a, a);
		add_test(k_branch, cpu_pkg::op_bne, a, a ^ 32'h1);
		add_test(k_zero, cpu_pkg::op_j, $urandom | 32'h1, $urandom);
	endtask

	//////////////////////////////
	// program builder
	//////////////////////////////
	task automatic load_program(input test_t t);
		for (int i = 0; i < MEM_WORDS; i++)
			imem[i] = j_word(i);            // every word spins in place
		pc_w = 0;
		emit(i_format(cpu_pkg::op_lui, 0, 1, t.a[31:16]));    // r1 = a
		emit(i_format(cpu_pkg::op_ori, 1, 1, t.a[15:0]));
		emit(i_format(cpu_pkg::op_lui, 0, 2, t.b[31:16]));    // r2 = b
		emit(i_format(cpu_pkg::op_ori, 2, 2, t.b[15:0]));
		case (t.kind)
			k_rtype: begin
				emit(r_format(1, 2, 3, cpu_pkg::funct_e'(t.code)));
				emit(i_format(cpu_pkg::op_sw, 0, 3, RES_ADDR[15:0]));
			end
			k_itype: begin
				emit(i_format(cpu_pkg::opcode_e'(t.code), 1, 3, t.b[15:0]));
				emit(i_format(cpu_pkg::op_sw, 0, 3, RES_ADDR[15:0]));
			end
			k_mem: begin
				emit(i_format(cpu_pkg::op_sw, 0, 1, PARK_ADDR[15:0]));
				emit(i_format(cpu_pkg::op_lw, 0, 4, PARK_ADDR[15:0]));
				emit(i_format(cpu_pkg::op_sw, 0, 4, RES_ADDR[15:0]));
			end
			k_branch: begin
				emit(i_format(cpu_pkg::op_addiu, 0, 3, 16'd1));    // marker
				emit(i_format(cpu_pkg::opcode_e'(t.code), 1, 2, 16'd1));
				emit(i_format(cpu_pkg::op_addiu, 0, 3, 16'd2));    // skipped when taken
				emit(i_format(cpu_pkg::op_sw, 0, 3, RES_ADDR[15:0]));
			end
			default: begin
				emit(r_format(1, 2, 0, cpu_pkg::fn_or));           // write to r0
				emit(i_format(cpu_pkg::op_sw, 0, 0, RES_ADDR[15:0]));
				emit(j_word(pc_w + 2));
				emit(i_format(cpu_pkg::op_sw, 0, 1, SKIP_ADDR[15:0]));   // jumped over
			end
		endcase
		emit(j_word(pc_w));
	endtask

	task automatic check_test(input int n, input test_t t);
		int exp_writes;
		bit ok;
		exp_writes = (t.kind == k_mem) ? 2 : 1;
		ok = 1'b1;
		if (stored !== t.exp) begin
			$display("[FAIL] test %0d %s: dmem_wdata_o 0x%08h, expected 0x%08h",
			         n, t.kind.name(), stored, t.exp);
			ok = 1'b0;
		end
		if (wr_count != exp_writes) begin
			$display("[FAIL] test %0d %s: dmem_wr_o pulses 0x%0h, expected 0x%0h",
			         n, t.kind.name(), wr_count, exp_writes);
			ok = 1'b0;
		end
		if (ok) begin
			n_pass++;
			$display("[PASS] test %0d %s code 0x%02h result 0x%08h", n, t.kind.name(),
			         t.code, stored);
		end else begin
			n_fail++;
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		rst    = 1'b1;
		n_pass = 0;
		n_fail = 0;
		void'($urandom(32'h0d219807));
		build_table();
		for (int n = 0; n < N_TESTS; n++) begin
			rst = 1'b1;
			load_program(tests[n]);
			repeat (2) @(negedge clk);
			rst = 1'b0;
			repeat (RUN_CYCLES) @(negedge clk);
			check_test(n, tests[n]);
		end
		$display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
		         N_TESTS, n_pass, n_fail, dut.u_props.fail_cnt);
		if (n_fail == 0 && dut.u_props.fail_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_decoder.sv
logic/cpu_regfile.sv
logic/cpu_alu.sv
logic/cpu_pc.sv
logic/cpu_core.sv
testbench/cpu_props.sv
testbench/cpu_tb.sv

// ==== Makefile ====
# Verilator flow for the single-cycle MIPS subset core

VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= cpu_tb
RTL_TOP   ?= cpu_core
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
